// File: verilog.f
+incdir+dv
src/rvPkg.sv
src/pipeIf.sv
src/fetchStage.sv
src/decodeStage.sv
src/hazardUnit.sv
src/executeStage.sv
src/memWbStage.sv
src/riscvTop.sv
dv/riscvTb.sv

// File: Makefile
# Verilator flow for the pipeline core, override any variable on the command line

VERILATOR ?= verilator
TOP       ?= riscvTb
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --timing -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// architectural model state, shares the scope of riscvTb
localparam logic [31:0] EBREAK = 32'h0010_0073;

logic [31:0] lcgState;
logic [31:0] regs [8];
logic [31:0] refMem [DMEM_WORDS];
logic [31:0] expCount;
// {rd, data}, {word addr, be, data}, {defined, value}
logic [36:0] regQ [$];
logic [47:0] storeQ [$];
logic [32:0] outQ [$];

function automatic logic [31:0] lcgNext();
   lcgState = lcgState * 32'd1103515245 + 32'd12345;
   // low bits of an lcg are weak
   return lcgState >> 15;
endfunction

function automatic logic [4:0] pickReg();
   logic [31:0] r;
   r = lcgNext();
   return {2'b00, r[2:0]};
endfunction

// odd multiplier keeps every address bit in the fill word
function automatic logic [31:0] fillWord(input int idx);
   return (32'(idx) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
endfunction

function automatic logic [31:0] byteMask(input logic [3:0] be);
   return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
endfunction

// rv32i encodings
function automatic logic [31:0] encR(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                     logic [4:0] rs1, logic [4:0] rs2);
   return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] encI(logic [11:0] imm, logic [2:0] f3, logic [4:0] rd,
                                     logic [4:0] rs1, logic [6:0] opc);
   return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] encS(logic [11:0] imm, logic [2:0] f3, logic [4:0] rs1,
                                     logic [4:0] rs2);
   return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] encB(logic [12:0] off, logic [2:0] f3, logic [4:0] rs1,
                                     logic [4:0] rs2);
   return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] encJ(logic [20:0] off, logic [4:0] rd);
   return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

task automatic initModels();
   lcgState = 32'h14d9;
   for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = EBREAK;
   end
   for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = fillWord(i);
      refMem[i] = fillWord(i);
   end
   for (int i = 0; i < 32; i++) begin
      rf[i] = '0;
   end
   for (int i = 0; i < 8; i++) begin
      regs[i] = '0;
   end
endtask

// generate in address order and execute along the way, jumps only go forward
task automatic buildProgram();
   logic [31:0] instr, a, b, res, addr, diff, r, data;
   logic [4:0] rd, rs1, rs2;
   logic [3:0] be;
   logic exec, taken, writes;
   int kind, off, next;
   next = 0;
   expCount = '0;
   for (int i = 0; i < PROG_LEN; i++) begin
      exec = (i == next);
      kind = int'(lcgNext() % 32'd13);
      rd = pickReg();
      rs1 = pickReg();
      rs2 = pickReg();
      a = regs[rs1[2:0]];
      b = regs[rs2[2:0]];
      writes = 1'b1;
      taken = 1'b0;
      addr = '0;
      off = 1 + int'(lcgNext() % 32'd4);
      // no target beyond the final ebreak
      if (i + off > PROG_LEN) begin
         off = PROG_LEN - i;
      end
      case (kind)
         0: begin
            instr = encR(7'h00, 3'd0, rd, rs1, rs2);
            res = a + b;
         end
         1: begin
            instr = encR(7'h20, 3'd0, rd, rs1, rs2);
            res = a - b;
         end
         2: begin
            instr = encR(7'h00, 3'd7, rd, rs1, rs2);
            res = a & b;
         end
         3: begin
            instr = encR(7'h00, 3'd6, rd, rs1, rs2);
            res = a | b;
         end
         4: begin
            instr = encR(7'h00, 3'd4, rd, rs1, rs2);
            res = a ^ b;
         end
         5: begin
            instr = encR(7'h00, 3'd2, rd, rs1, rs2);
            res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         end
         6: begin
            r = lcgNext();
            instr = encI(r[11:0], 3'd0, rd, rs1, 7'b0010011);
            res = a + {{20{r[11]}}, r[11:0]};
         end
         7, 8, 9: begin
            r = lcgNext();
            addr = WIN_BASE + ((kind == 9) ? (r % 32'd64) : ((r % 32'd16) << 2));
            diff = addr - a;
            // x0 base when the offset does not fit in 12 bits
            if (!exec || $signed(diff) > 2047 || $signed(diff) < -2048) begin
               rs1 = '0;
               diff = addr;
            end
            writes = (kind == 7);
            res = refMem[addr[13:2]];
            if (kind == 7) begin
               instr = encI(diff[11:0], 3'd2, rd, rs1, 7'b0000011);
            end else begin
               instr = encS(diff[11:0], (kind == 8) ? 3'd2 : 3'd0, rs1, rs2);
            end
         end
         10, 11: begin
            writes = 1'b0;
            instr = encB(13'(off * 4), (kind == 10) ? 3'd0 : 3'd1, rs1, rs2);
            taken = (kind == 10) ? (a == b) : (a != b);
         end
         default: begin
            instr = encJ(21'(off * 4), rd);
            taken = 1'b1;
            res = 32'(i * 4 + 4);
         end
      endcase
      imem[i] = instr;
      if (exec) begin
         expCount++;
         if (kind == 8 || kind == 9) begin
            be = (kind == 8) ? 4'hf : (4'b0001 << addr[1:0]);
            data = (kind == 8) ? b : {4{b[7:0]}};
            refMem[addr[13:2]] = (refMem[addr[13:2]] & ~byteMask(be)) | (data & byteMask(be));
            storeQ.push_back({addr[13:2], be, data});
            outQ.push_back({1'b1, addr});
         end else if (kind == 10 || kind == 11) begin
            outQ.push_back({1'b1, 31'd0, taken});
         end else begin
            outQ.push_back({1'b1, res});
         end
         if (writes && rd != 5'd0) begin
            regs[rd[2:0]] = res;
            regQ.push_back({rd, res});
         end
         next = taken ? i + off : i + 1;
      end
   end
   // the executed path always ends on the closing ebreak
   imem[PROG_LEN] = EBREAK;
   expCount++;
   outQ.push_back({1'b0, 32'd0});
endtask

`endif

// File: dv/riscvTb.sv
`timescale 1ns/1ps

module riscvTb;

   localparam int IMEM_WORDS = 1024;
   localparam int DMEM_WORDS = 4096;
   localparam int PROG_LEN = 120;
   localparam int MAX_CYCLES = 2000;
   // loads and stores stay inside this byte window
   localparam logic [31:0] WIN_BASE = 32'h100;

   logic CLK, RSTn;
   logic I_MEM_CSN, D_MEM_CSN, D_MEM_WEN, RF_WE, HALT;
   logic [31:0] I_MEM_DI, D_MEM_DI, D_MEM_DOUT, RF_RD1, RF_RD2, RF_WD;
   logic [31:0] NUM_INST, OUTPUT_PORT;
   logic [11:0] I_MEM_ADDR, D_MEM_ADDR;
   logic [3:0] D_MEM_BE;
   logic [4:0] RF_RA1, RF_RA2, RF_WA1;

   // memory and register file models
   logic [31:0] imem [IMEM_WORDS];
   logic [31:0] dmem [DMEM_WORDS];
   logic [31:0] rf [32];

   int errCount;
   logic [31:0] prevNum, prevOut;

   `include "isaModel.svh"

   riscvTop i_dut (.*);

   initial begin
      CLK = 1'b0;
      forever #5 CLK = ~CLK;
   end

   // combinational reads with a write-through rf where x0 reads zero
   assign I_MEM_DI = imem[I_MEM_ADDR[11:2]];
   assign D_MEM_DI = dmem[D_MEM_ADDR];
   assign RF_RD1 = (RF_RA1 == 5'd0) ? 32'd0 :
                   (RF_WE && RF_WA1 == RF_RA1) ? RF_WD : rf[RF_RA1];
   assign RF_RD2 = (RF_RA2 == 5'd0) ? 32'd0 :
                   (RF_WE && RF_WA1 == RF_RA2) ? RF_WD : rf[RF_RA2];

   // writes land at the edge after the dut has sampled read data
   always @(posedge CLK) begin
      if (RF_WE === 1'b1 && RF_WA1 != 5'd0) begin
         rf[RF_WA1] <= RF_WD;
      end
      if (D_MEM_CSN === 1'b0 && D_MEM_WEN === 1'b0) begin
         dmem[D_MEM_ADDR] <= (dmem[D_MEM_ADDR] & ~byteMask(D_MEM_BE)) |
                             (D_MEM_DOUT & byteMask(D_MEM_BE));
      end
   end

   task automatic stopWithFail(input string why);
      if (why != "") begin
         $display("%s", why);
      end
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped");
   endtask

   task automatic compareVal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp) begin
         errCount++;
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         stopWithFail("");
      end
   endtask

   task automatic expectResetState();
      compareVal("RF_WE", {31'd0, RF_WE}, 32'd0);
      compareVal("D_MEM_WEN", {31'd0, D_MEM_WEN}, 32'd1);
      compareVal("D_MEM_BE", {28'd0, D_MEM_BE}, 32'd0);
      compareVal("HALT", {31'd0, HALT}, 32'd0);
      compareVal("NUM_INST", NUM_INST, 32'd0);
   endtask

   task automatic regWriteMatch();
      logic [36:0] exp;
      if (regQ.size() == 0) begin
         stopWithFail("Error: register write seen with none expected");
      end else begin
         exp = regQ.pop_front();
         compareVal("RF_WA1", {27'd0, RF_WA1}, {27'd0, exp[36:32]});
         compareVal("RF_WD", RF_WD, exp[31:0]);
      end
   endtask

   task automatic storeMatch();
      logic [47:0] exp;
      logic [31:0] mask;
      if (storeQ.size() == 0) begin
         stopWithFail("Error: store seen with none expected");
      end else begin
         exp = storeQ.pop_front();
         mask = byteMask(exp[35:32]);
         compareVal("D_MEM_ADDR", {20'd0, D_MEM_ADDR}, {20'd0, exp[47:36]});
         compareVal("D_MEM_BE", {28'd0, D_MEM_BE}, {28'd0, exp[35:32]});
         // only the enabled lanes matter
         compareVal("D_MEM_DOUT", D_MEM_DOUT & mask, exp[31:0] & mask);
      end
   endtask

   task automatic testPortMatch();
      logic [32:0] exp;
      if (outQ.size() == 0) begin
         stopWithFail("Error: more instructions completed than the program executes");
      end else begin
         exp = outQ.pop_front();
         // bit 32 clear means no test port value is defined (ebreak)
         if (exp[32]) begin
            compareVal("OUTPUT_PORT", prevOut, exp[31:0]);
         end
      end
   endtask

   // sample in the middle of the cycle where everything is settled
   always @(negedge CLK) begin
      if (RSTn === 1'b0) begin
         // both memories stay selected while the core runs
         compareVal("I_MEM_CSN", {31'd0, I_MEM_CSN}, 32'd0);
         compareVal("D_MEM_CSN", {31'd0, D_MEM_CSN}, 32'd0);
         if (RF_WE && RF_WA1 != 5'd0) begin
            regWriteMatch();
         end
         if (!D_MEM_CSN && !D_MEM_WEN) begin
            storeMatch();
         end
         // the test port value belongs to the cycle before the count step
         if (NUM_INST == prevNum + 32'd1) begin
            testPortMatch();
         end else if (NUM_INST != prevNum) begin
            stopWithFail("Error: NUM_INST moved by more than one in a cycle");
         end
         prevNum = NUM_INST;
         prevOut = OUTPUT_PORT;
      end else begin
         compareVal("I_MEM_CSN", {31'd0, I_MEM_CSN}, 32'd1);
         compareVal("D_MEM_CSN", {31'd0, D_MEM_CSN}, 32'd1);
         prevNum = '0;
      end
   end

   task automatic endOfRun();
      // ebreak is counted at the edge that ends its wb cycle
      @(posedge CLK);
      #1;
      compareVal("NUM_INST", NUM_INST, expCount);
      repeat (2) @(negedge CLK);
      compareVal("HALT", {31'd0, HALT}, 32'd1);
      compareVal("NUM_INST", NUM_INST, expCount);
      if (regQ.size() != 0 || storeQ.size() != 0 || outQ.size() != 0) begin
         errCount++;
         $display("Error: %0d writes, %0d stores, %0d completions missing at HALT",
                  regQ.size(), storeQ.size(), outQ.size());
      end
      if (errCount == 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         stopWithFail("");
      end
   endtask

   initial begin
      int cycles;
      RSTn = 1'b1;
      errCount = 0;
      prevNum = '0;
      prevOut = '0;
      initModels();
      buildProgram();
      // reset held over three rising edges
      repeat (3) begin
         @(posedge CLK);
         #1;
         expectResetState();
      end
      RSTn = 1'b0;
      @(negedge CLK);
      expectResetState();
      cycles = 0;
      while (HALT !== 1'b1 && cycles < MAX_CYCLES) begin
         @(negedge CLK);
         cycles++;
      end
      if (HALT !== 1'b1) begin
         stopWithFail("Error: timeout, HALT did not rise within the cycle limit");
      end else begin
         endOfRun();
      end
   end

endmodule

// File: src/riscvTop.sv
`timescale 1ns/1ps

module riscvTop (
   input  logic        CLK,
   input  logic        RSTn,
   // instruction memory
   output logic        I_MEM_CSN,
   input  logic [31:0] I_MEM_DI,
   output logic [11:0] I_MEM_ADDR,
   // data memory
   output logic        D_MEM_CSN,
   input  logic [31:0] D_MEM_DI,
   output logic [31:0] D_MEM_DOUT,
   output logic [11:0] D_MEM_ADDR,
   output logic        D_MEM_WEN,
   output logic [3:0]  D_MEM_BE,
   // register file
   output logic        RF_WE,
   output logic [4:0]  RF_RA1,
   output logic [4:0]  RF_RA2,
   output logic [4:0]  RF_WA1,
   input  logic [31:0] RF_RD1,
   input  logic [31:0] RF_RD2,
   output logic [31:0] RF_WD,
   output logic        HALT,
   output logic [31:0] NUM_INST,
   output logic [31:0] OUTPUT_PORT
);

   logic redirect, flush, halted, ifValid;
   logic [31:0] target, ifInstr, ifPc, ifPc4;
   rvPkg::fwdSel_e fwdA, fwdB, fwdStore;

   idExIf idEx ();
   exMemIf exMem ();
   memWbIf memWb ();

   // memories are selected while the core runs
   assign I_MEM_CSN = RSTn;
   assign D_MEM_CSN = RSTn;

   fetchStage uFetch (
      .CLK(CLK), .RSTn(RSTn), .redirect(redirect), .target(target), .flush(flush),
      .halted(halted), .instrIn(I_MEM_DI), .iAddr(I_MEM_ADDR), .ifInstr(ifInstr),
      .ifPc(ifPc), .ifPc4(ifPc4), .ifValid(ifValid)
   );

   decodeStage uDecode (
      .CLK(CLK), .RSTn(RSTn), .flush(flush), .ifInstr(ifInstr), .ifPc(ifPc),
      .ifPc4(ifPc4), .ifValid(ifValid), .rfRd1(RF_RD1), .rfRd2(RF_RD2),
      .rfRa1(RF_RA1), .rfRa2(RF_RA2), .halted(halted), .idEx(idEx.src)
   );

   hazardUnit uHazard (
      .redirect(redirect), .fwdA(fwdA), .fwdB(fwdB), .fwdStore(fwdStore), .flush(flush),
      .idEx(idEx.dst), .exMem(exMem.dst), .memWb(memWb.dst)
   );

   executeStage uExecute (
      .CLK(CLK), .RSTn(RSTn), .fwdA(fwdA), .fwdB(fwdB), .fwdStore(fwdStore),
      .memData(D_MEM_DI), .redirect(redirect), .target(target),
      .idEx(idEx.dst), .exMem(exMem.src), .memWb(memWb.dst)
   );

   memWbStage uMemWb (
      .CLK(CLK), .RSTn(RSTn), .D_MEM_DI(D_MEM_DI), .D_MEM_ADDR(D_MEM_ADDR),
      .D_MEM_DOUT(D_MEM_DOUT), .D_MEM_WEN(D_MEM_WEN), .D_MEM_BE(D_MEM_BE),
      .RF_WE(RF_WE), .RF_WA1(RF_WA1), .RF_WD(RF_WD), .OUTPUT_PORT(OUTPUT_PORT),
      .HALT(HALT), .NUM_INST(NUM_INST), .exMem(exMem.dst), .memWb(memWb.src)
   );

endmodule

// File: src/memWbStage.sv
`timescale 1ns/1ps

module memWbStage (
   input  logic                     CLK,
   input  logic                     RSTn,
   input  logic [rvPkg::XLEN-1:0]   D_MEM_DI,
   output logic [rvPkg::ADDR_W-1:0] D_MEM_ADDR,
   output logic [rvPkg::XLEN-1:0]   D_MEM_DOUT,
   output logic                     D_MEM_WEN,
   output logic [3:0]               D_MEM_BE,
   output logic                     RF_WE,
   output logic [rvPkg::REG_W-1:0]  RF_WA1,
   output logic [rvPkg::XLEN-1:0]   RF_WD,
   output logic [rvPkg::XLEN-1:0]   OUTPUT_PORT,
   output logic                     HALT,
   output logic [rvPkg::XLEN-1:0]   NUM_INST,
   exMemIf.dst                      exMem,
   memWbIf.src                      memWb
);

   logic store, haltFlag;
   logic [rvPkg::XLEN-1:0] wbData;

   assign store = exMem.valid & exMem.memWrite;

   // dmem is word addressed
   assign D_MEM_ADDR = exMem.aluResult[rvPkg::ADDR_W+1:2];
   assign D_MEM_WEN = ~store;
   // sb enables one lane while sw and lw enable all four
   always_comb begin
      D_MEM_BE = 4'b0000;
      if (store && exMem.byteStore) begin
         D_MEM_BE = 4'b0001 << exMem.aluResult[1:0];
      end else if (store || (exMem.valid && exMem.memRead)) begin
         D_MEM_BE = 4'b1111;
      end
   end
   // byte stores replicate onto every lane
   assign D_MEM_DOUT = exMem.byteStore ? {4{exMem.storeData[7:0]}} : exMem.storeData;

   always_comb begin
      case (exMem.wbSel)
         rvPkg::WB_MEM: wbData = D_MEM_DI;
         rvPkg::WB_PC4: wbData = exMem.pc4;
         default: wbData = exMem.aluResult;
      endcase
   end

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         memWb.valid <= 1'b0;
         haltFlag <= 1'b0;
         NUM_INST <= '0;
      end else begin
         memWb.valid <= exMem.valid;
         // every valid entry leaving wb is a completed instruction
         if (memWb.valid) begin
            NUM_INST <= NUM_INST + 1'b1;
         end
         if (memWb.valid && memWb.isHalt) begin
            haltFlag <= 1'b1;
         end
      end
   end

   // mem/wb payload
   always_ff @(posedge CLK) begin
      memWb.rd <= exMem.rd;
      memWb.regWrite <= exMem.regWrite;
      memWb.wbData <= wbData;
      memWb.outSel <= exMem.outSel;
      memWb.addr <= exMem.aluResult;
      memWb.taken <= exMem.taken;
      memWb.isHalt <= exMem.isHalt;
   end

   // x0 is never written
   assign RF_WE = memWb.valid & memWb.regWrite & (memWb.rd != '0);
   assign RF_WA1 = memWb.rd;
   assign RF_WD = memWb.wbData;

   // halt shows in the wb cycle of ebreak and sticks
   assign HALT = haltFlag | (memWb.valid & memWb.isHalt);

   always_comb begin
      case (memWb.outSel)
         rvPkg::OUT_ADDR: OUTPUT_PORT = memWb.addr;
         rvPkg::OUT_BRANCH: OUTPUT_PORT = {31'b0, memWb.taken};
         default: OUTPUT_PORT = memWb.wbData;
      endcase
   end

   // nothing younger than ebreak may complete
   countFrozen: assert property (@(posedge CLK) disable iff (RSTn)
      haltFlag |=> $stable(NUM_INST));

endmodule

// File: src/executeStage.sv
`timescale 1ns/1ps

module executeStage (
   input  logic                   CLK,
   input  logic                   RSTn,
   input  rvPkg::fwdSel_e         fwdA,
   input  rvPkg::fwdSel_e         fwdB,
   input  rvPkg::fwdSel_e         fwdStore,
   input  logic [rvPkg::XLEN-1:0] memData,
   output logic                   redirect,
   output logic [rvPkg::XLEN-1:0] target,
   idExIf.dst                     idEx,
   exMemIf.src                    exMem,
   memWbIf.dst                    memWb
);

   logic [rvPkg::XLEN-1:0] exMemVal, rs1Val, rs2Val, storeVal, opA, opB, aluRes;
   logic regEq;

   function automatic logic [rvPkg::XLEN-1:0] fwdMux(
      input rvPkg::fwdSel_e sel,
      input logic [rvPkg::XLEN-1:0] regVal,
      input logic [rvPkg::XLEN-1:0] exVal,
      input logic [rvPkg::XLEN-1:0] mdVal,
      input logic [rvPkg::XLEN-1:0] wbVal
   );
      case (sel)
         rvPkg::FWD_EXMEM: return exVal;
         rvPkg::FWD_MEMDATA: return mdVal;
         rvPkg::FWD_MEMWB: return wbVal;
         default: return regVal;
      endcase
   endfunction

   // a jal in mem forwards its link value, not the alu sum
   assign exMemVal = (exMem.wbSel == rvPkg::WB_PC4) ? exMem.pc4 : exMem.aluResult;

   assign rs1Val = fwdMux(fwdA, idEx.rs1Data, exMemVal, memData, memWb.wbData);
   assign rs2Val = fwdMux(fwdB, idEx.rs2Data, exMemVal, memData, memWb.wbData);
   assign storeVal = fwdMux(fwdStore, idEx.rs2Data, exMemVal, memData, memWb.wbData);

   assign opA = idEx.aluSrcA ? idEx.pc : rs1Val;
   assign opB = idEx.aluSrcB ? idEx.imm : rs2Val;

   always_comb begin
      case (idEx.aluOp)
         rvPkg::ALU_SUB: aluRes = opA - opB;
         rvPkg::ALU_AND: aluRes = opA & opB;
         rvPkg::ALU_OR: aluRes = opA | opB;
         rvPkg::ALU_XOR: aluRes = opA ^ opB;
         rvPkg::ALU_SLT: aluRes = {31'b0, $signed(opA) < $signed(opB)};
         default: aluRes = opA + opB;
      endcase
   end

   // beq/bne compare the forwarded register values
   assign regEq = rs1Val == rs2Val;
   assign redirect = idEx.valid & (idEx.isJump | (idEx.isBranch & (regEq ^ idEx.branchNe)));
   // for branches and jal the alu computes pc plus imm
   assign target = aluRes;

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         exMem.valid <= 1'b0;
      end else begin
         exMem.valid <= idEx.valid;
      end
   end

   // ex/mem payload
   always_ff @(posedge CLK) begin
      exMem.aluResult <= aluRes;
      exMem.storeData <= storeVal;
      exMem.pc4 <= idEx.pc4;
      exMem.rd <= idEx.rd;
      exMem.regWrite <= idEx.regWrite;
      exMem.memRead <= idEx.memRead;
      exMem.memWrite <= idEx.memWrite;
      exMem.byteStore <= idEx.byteStore;
      exMem.wbSel <= idEx.wbSel;
      exMem.outSel <= idEx.outSel;
      exMem.taken <= redirect;
      exMem.isHalt <= idEx.isHalt;
   end

endmodule

// File: src/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
   input  logic            redirect,
   output rvPkg::fwdSel_e  fwdA,
   output rvPkg::fwdSel_e  fwdB,
   output rvPkg::fwdSel_e  fwdStore,
   output logic            flush,
   idExIf.dst              idEx,
   exMemIf.dst             exMem,
   memWbIf.dst             memWb
);

   logic exWr, wbWr;
   rvPkg::fwdSel_e rs2Sel;

   // youngest producer wins, x0 is never forwarded
   function automatic rvPkg::fwdSel_e pick(
      input logic [rvPkg::REG_W-1:0] src,
      input logic [rvPkg::REG_W-1:0] exRd,
      input logic exHit,
      input logic exLoad,
      input logic [rvPkg::REG_W-1:0] wbRd,
      input logic wbHit
   );
      if (src == '0) begin
         return rvPkg::FWD_NONE;
      end else if (exHit && exRd == src) begin
         // load data comes straight off the dmem read port
         return exLoad ? rvPkg::FWD_MEMDATA : rvPkg::FWD_EXMEM;
      end else if (wbHit && wbRd == src) begin
         return rvPkg::FWD_MEMWB;
      end
      return rvPkg::FWD_NONE;
   endfunction

   assign exWr = exMem.valid & exMem.regWrite;
   assign wbWr = memWb.valid & memWb.regWrite;

   assign fwdA = pick(idEx.rs1, exMem.rd, exWr, exMem.memRead, memWb.rd, wbWr);
   assign rs2Sel = pick(idEx.rs2, exMem.rd, exWr, exMem.memRead, memWb.rd, wbWr);

   // rs2 feeds either the alu/compare path or the store data path
   assign fwdB = idEx.memWrite ? rvPkg::FWD_NONE : rs2Sel;
   assign fwdStore = idEx.memWrite ? rs2Sel : rvPkg::FWD_NONE;

   // taken branch or jal kills if/id and id/ex
   assign flush = redirect;

endmodule

// File: src/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
   input  logic                    CLK,
   input  logic                    RSTn,
   input  logic                    flush,
   input  logic [rvPkg::XLEN-1:0]  ifInstr,
   input  logic [rvPkg::XLEN-1:0]  ifPc,
   input  logic [rvPkg::XLEN-1:0]  ifPc4,
   input  logic                    ifValid,
   input  logic [rvPkg::XLEN-1:0]  rfRd1,
   input  logic [rvPkg::XLEN-1:0]  rfRd2,
   output logic [rvPkg::REG_W-1:0] rfRa1,
   output logic [rvPkg::REG_W-1:0] rfRa2,
   output logic                    halted,
   idExIf.src                      idEx
);

   rvPkg::opcode_e opc;
   rvPkg::aluOp_e aluOp;
   rvPkg::wbSel_e wbSel;
   rvPkg::outSel_e outSel;
   logic [2:0] funct3;
   logic [rvPkg::XLEN-1:0] imm, immI, immS, immB, immJ;
   logic known, useRs1, useRs2, aluSrcA, aluSrcB, isBranch, isJump;
   logic memRead, memWrite, regWrite, isHalt, decHalt, haltSeen;

   assign opc = rvPkg::opcode_e'(ifInstr[6:0]);
   assign funct3 = ifInstr[14:12];

   // immediate formats
   assign immI = {{20{ifInstr[31]}}, ifInstr[31:20]};
   assign immS = {{20{ifInstr[31]}}, ifInstr[31:25], ifInstr[11:7]};
   assign immB = {{19{ifInstr[31]}}, ifInstr[31], ifInstr[7], ifInstr[30:25],
                  ifInstr[11:8], 1'b0};
   assign immJ = {{11{ifInstr[31]}}, ifInstr[31], ifInstr[19:12], ifInstr[20],
                  ifInstr[30:21], 1'b0};

   always_comb begin
      known = 1'b1;
      useRs1 = 1'b1;
      useRs2 = 1'b0;
      aluSrcA = 1'b0;
      aluSrcB = 1'b1;
      imm = immI;
      isBranch = 1'b0;
      isJump = 1'b0;
      memRead = 1'b0;
      memWrite = 1'b0;
      regWrite = 1'b0;
      isHalt = 1'b0;
      wbSel = rvPkg::WB_ALU;
      outSel = rvPkg::OUT_WB;
      case (opc)
         rvPkg::OP: begin
            useRs2 = 1'b1;
            aluSrcB = 1'b0;
            regWrite = 1'b1;
         end
         rvPkg::OP_IMM: regWrite = 1'b1;
         rvPkg::LOAD: begin
            memRead = 1'b1;
            regWrite = 1'b1;
            wbSel = rvPkg::WB_MEM;
         end
         rvPkg::STORE: begin
            useRs2 = 1'b1;
            imm = immS;
            memWrite = 1'b1;
            outSel = rvPkg::OUT_ADDR;
         end
         // alu forms the target as pc plus imm
         rvPkg::BRANCH: begin
            useRs2 = 1'b1;
            aluSrcA = 1'b1;
            imm = immB;
            isBranch = 1'b1;
            outSel = rvPkg::OUT_BRANCH;
         end
         rvPkg::JAL: begin
            useRs1 = 1'b0;
            aluSrcA = 1'b1;
            imm = immJ;
            isJump = 1'b1;
            regWrite = 1'b1;
            wbSel = rvPkg::WB_PC4;
         end
         // only ebreak is kept from the system group
         rvPkg::SYSTEM: begin
            useRs1 = 1'b0;
            isHalt = ifInstr == rvPkg::EBREAK_INSTR;
            known = isHalt;
         end
         default: known = 1'b0;
      endcase
   end

   // funct7 bit 5 turns add into sub for register ops
   always_comb begin
      case (funct3)
         3'b010: aluOp = rvPkg::ALU_SLT;
         3'b100: aluOp = rvPkg::ALU_XOR;
         3'b110: aluOp = rvPkg::ALU_OR;
         3'b111: aluOp = rvPkg::ALU_AND;
         default: begin
            aluOp = (opc == rvPkg::OP && ifInstr[30]) ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
         end
      endcase
      if (opc != rvPkg::OP && opc != rvPkg::OP_IMM) begin
         aluOp = rvPkg::ALU_ADD;
      end
   end

   // unused sources read x0 so forwarding ignores them
   assign rfRa1 = useRs1 ? ifInstr[19:15] : '0;
   assign rfRa2 = useRs2 ? ifInstr[24:20] : '0;

   // a flushed ebreak must not stop fetch
   assign decHalt = ifValid & isHalt & ~flush;
   assign halted = haltSeen | decHalt;

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         idEx.valid <= 1'b0;
         haltSeen <= 1'b0;
      end else begin
         idEx.valid <= ifValid & known & ~flush & ~haltSeen;
         if (decHalt) begin
            haltSeen <= 1'b1;
         end
      end
   end

   // id/ex payload
   always_ff @(posedge CLK) begin
      idEx.pc <= ifPc;
      idEx.pc4 <= ifPc4;
      idEx.rs1 <= rfRa1;
      idEx.rs2 <= rfRa2;
      idEx.rd <= ifInstr[11:7];
      idEx.rs1Data <= rfRd1;
      idEx.rs2Data <= rfRd2;
      idEx.imm <= imm;
      idEx.aluOp <= aluOp;
      idEx.aluSrcA <= aluSrcA;
      idEx.aluSrcB <= aluSrcB;
      idEx.isBranch <= isBranch;
      idEx.branchNe <= funct3[0];
      idEx.isJump <= isJump;
      idEx.memRead <= memRead;
      idEx.memWrite <= memWrite;
      idEx.byteStore <= funct3 == 3'b000;
      idEx.regWrite <= regWrite;
      idEx.wbSel <= wbSel;
      idEx.outSel <= outSel;
      idEx.isHalt <= isHalt;
   end

   // nothing younger than a valid ebreak reaches execute
   haltIsLast: assert property (@(posedge CLK) disable iff (RSTn)
      idEx.valid && idEx.isHalt |=> !idEx.valid);

endmodule

// File: src/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
   input  logic                     CLK,
   input  logic                     RSTn,
   input  logic                     redirect,
   input  logic [rvPkg::XLEN-1:0]   target,
   input  logic                     flush,
   input  logic                     halted,
   input  logic [rvPkg::XLEN-1:0]   instrIn,
   output logic [rvPkg::ADDR_W-1:0] iAddr,
   output logic [rvPkg::XLEN-1:0]   ifInstr,
   output logic [rvPkg::XLEN-1:0]   ifPc,
   output logic [rvPkg::XLEN-1:0]   ifPc4,
   output logic                     ifValid
);

   logic [rvPkg::XLEN-1:0] pc, pc4;

   assign pc4 = pc + 32'd4;
   // imem takes a byte address
   assign iAddr = pc[rvPkg::ADDR_W-1:0];

   // pc freezes once ebreak sits in decode
   always_ff @(posedge CLK) begin
      if (RSTn) begin
         pc <= '0;
         ifValid <= 1'b0;
      end else begin
         if (!halted) begin
            pc <= redirect ? target : pc4;
         end
         // wrong-path fetch or anything after ebreak becomes a bubble
         ifValid <= ~halted & ~flush;
      end
   end

   // if/id payload
   always_ff @(posedge CLK) begin
      ifInstr <= instrIn;
      ifPc <= pc;
      ifPc4 <= pc4;
   end

   // targets are pc plus an even immediate, only word ones are legal here
   pcAligned: assert property (@(posedge CLK) disable iff (RSTn) pc[1:0] == 2'b00);

endmodule

// File: src/pipeIf.sv
`timescale 1ns/1ps

// id/ex pipeline register contents
interface idExIf;
   logic valid;
   logic [rvPkg::XLEN-1:0] pc, pc4;
   logic [rvPkg::REG_W-1:0] rs1, rs2, rd;
   logic [rvPkg::XLEN-1:0] rs1Data, rs2Data, imm;
   rvPkg::aluOp_e aluOp;
   // srcA picks pc, srcB picks imm
   logic aluSrcA, aluSrcB;
   logic isBranch, branchNe, isJump;
   logic memRead, memWrite, byteStore;
   logic regWrite;
   rvPkg::wbSel_e wbSel;
   rvPkg::outSel_e outSel;
   logic isHalt;

   modport src (output valid, pc, pc4, rs1, rs2, rd, rs1Data, rs2Data, imm, aluOp,
      aluSrcA, aluSrcB, isBranch, branchNe, isJump, memRead, memWrite, byteStore,
      regWrite, wbSel, outSel, isHalt);
   modport dst (input valid, pc, pc4, rs1, rs2, rd, rs1Data, rs2Data, imm, aluOp,
      aluSrcA, aluSrcB, isBranch, branchNe, isJump, memRead, memWrite, byteStore,
      regWrite, wbSel, outSel, isHalt);
endinterface

// ex/mem pipeline register contents
interface exMemIf;
   logic valid;
   logic [rvPkg::XLEN-1:0] aluResult, storeData, pc4;
   logic [rvPkg::REG_W-1:0] rd;
   logic regWrite, memRead, memWrite, byteStore;
   rvPkg::wbSel_e wbSel;
   rvPkg::outSel_e outSel;
   logic taken, isHalt;

   modport src (output valid, aluResult, storeData, pc4, rd, regWrite, memRead, memWrite,
      byteStore, wbSel, outSel, taken, isHalt);
   modport dst (input valid, aluResult, storeData, pc4, rd, regWrite, memRead, memWrite,
      byteStore, wbSel, outSel, taken, isHalt);
endinterface

// mem/wb pipeline register contents
interface memWbIf;
   logic valid;
   logic [rvPkg::REG_W-1:0] rd;
   logic regWrite;
   logic [rvPkg::XLEN-1:0] wbData, addr;
   rvPkg::outSel_e outSel;
   logic taken, isHalt;

   modport src (output valid, rd, regWrite, wbData, outSel, addr, taken, isHalt);
   modport dst (input valid, rd, regWrite, wbData, outSel, addr, taken, isHalt);
endinterface

// File: src/rvPkg.sv
package rvPkg;

   // datapath and memory widths
   localparam int XLEN = 32;
   localparam int ADDR_W = 12;
   localparam int REG_W = 5;

   // ebreak is the halt instruction of this core
   localparam logic [XLEN-1:0] EBREAK_INSTR = 32'h0010_0073;

   // major opcodes of the kept rv32i subset
   typedef enum logic [6:0] {
      OP     = 7'b0110011,
      OP_IMM = 7'b0010011,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      BRANCH = 7'b1100011,
      JAL    = 7'b1101111,
      SYSTEM = 7'b1110011
   } opcode_e;

   // alu operations, slt is signed
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT
   } aluOp_e;

   // write-back source
   typedef enum logic [1:0] {
      WB_ALU,
      WB_MEM,
      WB_PC4
   } wbSel_e;

   // ex operand source, memdata is the load data of the mem stage
   typedef enum logic [1:0] {
      FWD_NONE,
      FWD_EXMEM,
      FWD_MEMDATA,
      FWD_MEMWB
   } fwdSel_e;

   // what the test port shows per instruction
   typedef enum logic [1:0] {
      OUT_WB,
      OUT_ADDR,
      OUT_BRANCH
   } outSel_e;

endpackage
